//--- verilog/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Translation buffer geometry
`define MMU_TLB_ENTRIES 16
`define MMU_IDX_W       4

// Address widths
`define MMU_VA_W        32
`define MMU_PA_W        32

// Register numbers on the bus
`define MMU_CSR_ADR_W   14
`define MMU_CSR_CRMD    14'h000
`define MMU_CSR_TLBIDX  14'h010
`define MMU_CSR_TLBEHI  14'h011
`define MMU_CSR_TLBELO0 14'h012
`define MMU_CSR_TLBELO1 14'h013
`define MMU_CSR_ASID    14'h018
`define MMU_CSR_DMW0    14'h180
`define MMU_CSR_DMW1    14'h181
`define MMU_CSR_TLBCMD  14'h1FF

`endif

//--- verilog/csr_pkg.sv
`include "mmu_cfg.svh"

package csr_pkg;

    // Current mode
    typedef struct packed {
        logic [22:0] rsv_31_9;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        rsv_2;
        logic [1:0]  plv;
    } crmd_t;

    // Direct-mapped window
    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsv_28;
        logic [2:0]  pseg;
        logic [18:0] rsv_24_6;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  rsv_2_1;
        logic        plv0;
    } dmw_t;

    // Staging page descriptor
    typedef struct packed {
        logic [19:0] ppn;
        logic [4:0]  rsv_11_7;
        logic        g;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlbelo_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic [12:0] rsv_12_0;
    } tlbehi_t;

    typedef struct packed {
        logic        ne;
        logic [26:0] rsv_30_4;
        logic [3:0]  index;
    } tlbidx_t;

    // What the translation ports see
    typedef struct packed {
        crmd_t       crmd;
        dmw_t        dmw0;
        dmw_t        dmw1;
        logic [9:0]  asid;
    } xlate_ctrl_t;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`MMU_CSR_ADR_W-1:0] adr;
        logic [31:0]               dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- verilog/tlb_pkg.sv
`include "mmu_cfg.svh"

package tlb_pkg;

    typedef struct packed {
        logic                    v;
        logic [1:0]              mat;
        logic [`MMU_PA_W-13:0]   ppn;
    } tlb_page_t;

    // One even/odd page pair
    typedef struct packed {
        logic                    e;
        logic                    g;
        logic [9:0]              asid;
        logic [`MMU_VA_W-14:0]   vppn;
        tlb_page_t               even;
        tlb_page_t               odd;
    } tlb_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [`MMU_IDX_W-1:0]   index;
        tlb_entry_t              entry;
    } tlb_wr_t;

    typedef struct packed {
        logic                    found;
        tlb_page_t               page;
    } tlb_hit_t;

    typedef enum logic [1:0] {
        XLATE_DIRECT = 2'd0,
        XLATE_DMW    = 2'd1,
        XLATE_TLB    = 2'd2,
        XLATE_MISS   = 2'd3
    } xlate_src_e;

    typedef struct packed {
        logic                    valid;
        logic [`MMU_VA_W-1:0]    vaddr;
    } xlate_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`MMU_PA_W-1:0]    paddr;
        logic [1:0]              mat;
        xlate_src_e              src;
        logic                    invalid;
    } xlate_rsp_t;

endpackage

//--- verilog/mmu_csr.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_csr
    import csr_pkg::*;
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  wb_req_t     wb_i,
    output wb_rsp_t     wb_o,
    output xlate_ctrl_t ctrl_o,
    output tlb_wr_t     tlb_wr_o
);

    // Writable fields per register
    localparam logic [31:0] CRMD_MASK   = 32'h0000_01FB;
    localparam logic [31:0] DMW_MASK    = 32'hEE00_0039;
    localparam logic [31:0] TLBELO_MASK = 32'hFFFF_F07F;
    localparam logic [31:0] TLBEHI_MASK = 32'hFFFF_E000;
    localparam logic [31:0] TLBIDX_MASK = 32'h8000_000F;

    crmd_t      crmd_q;
    dmw_t       dmw0_q;
    dmw_t       dmw1_q;
    tlbelo_t    tlbelo0_q;
    tlbelo_t    tlbelo1_q;
    tlbehi_t    tlbehi_q;
    tlbidx_t    tlbidx_q;
    logic [9:0] asid_q;

    logic        ack_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;
    logic        access;
    logic        wr_en;
    logic        wr_pulse_q;

    // New access is sampled only while ack is low
    assign access = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr_en  = access && wb_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            wr_pulse_q <= 1'b0;
        end else begin
            ack_q      <= access;
            wr_pulse_q <= wr_en && (wb_i.adr == `MMU_CSR_TLBCMD);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_q    <= crmd_t'(32'h0000_0008);
            dmw0_q    <= '0;
            dmw1_q    <= '0;
            tlbelo0_q <= '0;
            tlbelo1_q <= '0;
            tlbehi_q  <= '0;
            tlbidx_q  <= '0;
            asid_q    <= '0;
        end else if (wr_en) begin
            case (wb_i.adr)
                `MMU_CSR_CRMD:    crmd_q    <= crmd_t'(wb_i.dat & CRMD_MASK);
                `MMU_CSR_ASID:    asid_q    <= wb_i.dat[9:0];
                `MMU_CSR_TLBIDX:  tlbidx_q  <= tlbidx_t'(wb_i.dat & TLBIDX_MASK);
                `MMU_CSR_TLBEHI:  tlbehi_q  <= tlbehi_t'(wb_i.dat & TLBEHI_MASK);
                `MMU_CSR_TLBELO0: tlbelo0_q <= tlbelo_t'(wb_i.dat & TLBELO_MASK);
                `MMU_CSR_TLBELO1: tlbelo1_q <= tlbelo_t'(wb_i.dat & TLBELO_MASK);
                `MMU_CSR_DMW0:    dmw0_q    <= dmw_t'(wb_i.dat & DMW_MASK);
                `MMU_CSR_DMW1:    dmw1_q    <= dmw_t'(wb_i.dat & DMW_MASK);
                default: ;
            endcase
        end
    end

    // Unmapped numbers and the command register read zero
    always_comb begin
        rd_data = '0;
        case (wb_i.adr)
            `MMU_CSR_CRMD:    rd_data = crmd_q;
            `MMU_CSR_ASID:    rd_data = {22'b0, asid_q};
            `MMU_CSR_TLBIDX:  rd_data = tlbidx_q;
            `MMU_CSR_TLBEHI:  rd_data = tlbehi_q;
            `MMU_CSR_TLBELO0: rd_data = tlbelo0_q;
            `MMU_CSR_TLBELO1: rd_data = tlbelo1_q;
            `MMU_CSR_DMW0:    rd_data = dmw0_q;
            `MMU_CSR_DMW1:    rd_data = dmw1_q;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access && !wb_i.we) begin
            dat_q <= rd_data;
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;

    assign ctrl_o.crmd = crmd_q;
    assign ctrl_o.dmw0 = dmw0_q;
    assign ctrl_o.dmw1 = dmw1_q;
    assign ctrl_o.asid = asid_q;

    function automatic tlb_page_t lo_to_page(tlbelo_t lo);
        tlb_page_t pg;
        pg.v   = lo.v;
        pg.mat = lo.mat;
        pg.ppn = lo.ppn;
        return pg;
    endfunction

    // Staging registers are stable during the pulse, ack blocks new writes
    assign tlb_wr_o.valid      = wr_pulse_q;
    assign tlb_wr_o.index      = tlbidx_q.index;
    assign tlb_wr_o.entry.e    = !tlbidx_q.ne;
    assign tlb_wr_o.entry.g    = tlbelo0_q.g & tlbelo1_q.g;
    assign tlb_wr_o.entry.asid = asid_q;
    assign tlb_wr_o.entry.vppn = tlbehi_q.vppn;
    assign tlb_wr_o.entry.even = lo_to_page(tlbelo0_q);
    assign tlb_wr_o.entry.odd  = lo_to_page(tlbelo1_q);

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i) wb_o.ack |=> !wb_o.ack
    );

endmodule

//--- verilog/tlb_array.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_array
    import tlb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  tlb_wr_t              tlb_wr_i,
    input  logic [9:0]           asid_i,
    input  logic [`MMU_VA_W-1:0] fetch_vaddr_i,
    input  logic [`MMU_VA_W-1:0] data_vaddr_i,
    output tlb_hit_t             fetch_hit_o,
    output tlb_hit_t             data_hit_o
);

    tlb_entry_t entry_q [`MMU_TLB_ENTRIES];

    // Port 0 is fetch, port 1 is data
    logic [`MMU_VA_W-1:0] va  [2];
    tlb_hit_t             hit [2];

    // Only the enable bits are cleared
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                entry_q[i].e <= 1'b0;
            end
        end else if (tlb_wr_i.valid) begin
            entry_q[tlb_wr_i.index] <= tlb_wr_i.entry;
        end
    end

    assign va[0] = fetch_vaddr_i;
    assign va[1] = data_vaddr_i;

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [`MMU_TLB_ENTRIES-1:0] match;

        always_comb begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                match[i] = entry_q[i].e
                        && (entry_q[i].vppn == va[p][`MMU_VA_W-1:13])
                        && (entry_q[i].g || (entry_q[i].asid == asid_i));
            end
        end

        // Bit 12 picks the odd page of the pair
        always_comb begin
            hit[p] = '0;
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                if (match[i]) begin
                    hit[p].found = 1'b1;
                    hit[p].page  = va[p][12] ? entry_q[i].odd : entry_q[i].even;
                end
            end
        end

        // Software must not load overlapping pairs
        single_match: assert property (
            @(posedge clk) disable iff (!rst_n_i) $onehot0(match)
        );
    end

    assign fetch_hit_o = hit[0];
    assign data_hit_o  = hit[1];

endmodule

//--- verilog/addr_xlate.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module addr_xlate
    import csr_pkg::*;
    import tlb_pkg::*;
#(
    parameter bit IS_FETCH = 1'b1
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  xlate_ctrl_t ctrl_i,
    input  xlate_req_t  req_i,
    input  tlb_hit_t    hit_i,
    output xlate_rsp_t  rsp_o
);

    xlate_rsp_t rsp_d;
    xlate_rsp_t rsp_q;
    logic       valid_q;
    logic       dmw0_hit;
    logic       dmw1_hit;

    // Window enable is per privilege level, only 0 and 3 exist
    function automatic logic dmw_match(dmw_t w, logic [1:0] plv, logic [2:0] seg);
        logic plv_ok;
        plv_ok = ((plv == 2'd0) && w.plv0) || ((plv == 2'd3) && w.plv3);
        return plv_ok && (w.vseg == seg);
    endfunction

    assign dmw0_hit = dmw_match(ctrl_i.dmw0, ctrl_i.crmd.plv, req_i.vaddr[31:29]);
    assign dmw1_hit = dmw_match(ctrl_i.dmw1, ctrl_i.crmd.plv, req_i.vaddr[31:29]);

    always_comb begin
        rsp_d = '0;
        if (ctrl_i.crmd.da) begin
            rsp_d.paddr = req_i.vaddr;
            rsp_d.mat   = IS_FETCH ? ctrl_i.crmd.datf : ctrl_i.crmd.datm;
            rsp_d.src   = XLATE_DIRECT;
        end else if (dmw0_hit) begin
            rsp_d.paddr = {ctrl_i.dmw0.pseg, req_i.vaddr[28:0]};
            rsp_d.mat   = ctrl_i.dmw0.mat;
            rsp_d.src   = XLATE_DMW;
        end else if (dmw1_hit) begin
            rsp_d.paddr = {ctrl_i.dmw1.pseg, req_i.vaddr[28:0]};
            rsp_d.mat   = ctrl_i.dmw1.mat;
            rsp_d.src   = XLATE_DMW;
        end else if (hit_i.found) begin
            rsp_d.paddr   = {hit_i.page.ppn, req_i.vaddr[11:0]};
            rsp_d.mat     = hit_i.page.mat;
            rsp_d.src     = XLATE_TLB;
            rsp_d.invalid = !hit_i.page.v;
        end else begin
            rsp_d.src = XLATE_MISS;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            rsp_q <= rsp_d;
        end
    end

    always_comb begin
        rsp_o       = rsp_q;
        rsp_o.valid = valid_q;
    end

    rsp_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (rsp_o.valid == $past(req_i.valid))
    );

endmodule

//--- verilog/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_top
    import csr_pkg::*;
    import tlb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  wb_req_t    wb_i,
    output wb_rsp_t    wb_o,
    input  xlate_req_t fetch_req_i,
    output xlate_rsp_t fetch_rsp_o,
    input  xlate_req_t data_req_i,
    output xlate_rsp_t data_rsp_o
);

    xlate_ctrl_t ctrl;
    tlb_wr_t     tlb_wr;
    tlb_hit_t    fetch_hit;
    tlb_hit_t    data_hit;

    mmu_csr u_csr (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb_i),
        .wb_o     (wb_o),
        .ctrl_o   (ctrl),
        .tlb_wr_o (tlb_wr)
    );

    tlb_array u_tlb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .tlb_wr_i      (tlb_wr),
        .asid_i        (ctrl.asid),
        .fetch_vaddr_i (fetch_req_i.vaddr),
        .data_vaddr_i  (data_req_i.vaddr),
        .fetch_hit_o   (fetch_hit),
        .data_hit_o    (data_hit)
    );

    addr_xlate #(
        .IS_FETCH (1'b1)
    ) u_fetch_xlate (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ctrl_i  (ctrl),
        .req_i   (fetch_req_i),
        .hit_i   (fetch_hit),
        .rsp_o   (fetch_rsp_o)
    );

    addr_xlate #(
        .IS_FETCH (1'b0)
    ) u_data_xlate (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ctrl_i  (ctrl),
        .req_i   (data_req_i),
        .hit_i   (data_hit),
        .rsp_o   (data_rsp_o)
    );

endmodule

//--- dv/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_tb
    import csr_pkg::*;
    import tlb_pkg::*;
();

    localparam int          DRIVE_DLY = 1;
    localparam logic [31:0] SEED      = 32'h25ade454;
    // All tests take about 400 cycles of bus traffic and requests
    localparam int          WATCHDOG_CYCLES = 2000;

    logic       clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    xlate_req_t fetch_req;
    xlate_req_t data_req;
    xlate_rsp_t fetch_rsp;
    xlate_rsp_t data_rsp;
    xlate_rsp_t fetch_exp;
    xlate_rsp_t data_exp;
    xlate_rsp_t fetch_exp_q;
    xlate_rsp_t data_exp_q;
    string      test_name;

    // Register and entry mirror
    logic [31:0] m_crmd;
    logic [31:0] m_asid;
    logic [31:0] m_idx;
    logic [31:0] m_ehi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [31:0] m_dmw0;
    logic [31:0] m_dmw1;
    logic        m_e     [`MMU_TLB_ENTRIES];
    logic        m_g     [`MMU_TLB_ENTRIES];
    logic [9:0]  m_easid [`MMU_TLB_ENTRIES];
    logic [18:0] m_vppn  [`MMU_TLB_ENTRIES];
    logic [31:0] m_even  [`MMU_TLB_ENTRIES];
    logic [31:0] m_odd   [`MMU_TLB_ENTRIES];

    mmu_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .wb_i        (wb_req),
        .wb_o        (wb_rsp),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_value(input string check, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
        $display("Fail %s (%s): expected %h actual %h", test_name, check, exp_val, act_val);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("Error in %s: %s", test_name, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at first error");
    endtask

    function automatic logic [13:0] csr_addr(input int k);
        case (k)
            0:       return `MMU_CSR_CRMD;
            1:       return `MMU_CSR_ASID;
            2:       return `MMU_CSR_TLBIDX;
            3:       return `MMU_CSR_TLBEHI;
            4:       return `MMU_CSR_TLBELO0;
            5:       return `MMU_CSR_TLBELO1;
            6:       return `MMU_CSR_DMW0;
            7:       return `MMU_CSR_DMW1;
            8:       return `MMU_CSR_TLBCMD;
            default: return 14'h0055;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] adr);
        case (adr)
            `MMU_CSR_CRMD:    return m_crmd;
            `MMU_CSR_ASID:    return m_asid;
            `MMU_CSR_TLBIDX:  return m_idx;
            `MMU_CSR_TLBEHI:  return m_ehi;
            `MMU_CSR_TLBELO0: return m_lo0;
            `MMU_CSR_TLBELO1: return m_lo1;
            `MMU_CSR_DMW0:    return m_dmw0;
            `MMU_CSR_DMW1:    return m_dmw1;
            default:          return 32'h0;
        endcase
    endfunction

    // Field masks follow the register layouts
    task automatic model_write(input logic [13:0] adr, input logic [31:0] dat);
        logic [3:0] idx;
        idx = m_idx[3:0];
        case (adr)
            `MMU_CSR_CRMD:    m_crmd = dat & 32'h0000_01FB;
            `MMU_CSR_ASID:    m_asid = dat & 32'h0000_03FF;
            `MMU_CSR_TLBIDX:  m_idx  = dat & 32'h8000_000F;
            `MMU_CSR_TLBEHI:  m_ehi  = dat & 32'hFFFF_E000;
            `MMU_CSR_TLBELO0: m_lo0  = dat & 32'hFFFF_F07F;
            `MMU_CSR_TLBELO1: m_lo1  = dat & 32'hFFFF_F07F;
            `MMU_CSR_DMW0:    m_dmw0 = dat & 32'hEE00_0039;
            `MMU_CSR_DMW1:    m_dmw1 = dat & 32'hEE00_0039;
            `MMU_CSR_TLBCMD: begin
                m_e[idx]     = !m_idx[31];
                m_g[idx]     = m_lo0[6] & m_lo1[6];
                m_easid[idx] = m_asid[9:0];
                m_vppn[idx]  = m_ehi[31:13];
                m_even[idx]  = m_lo0;
                m_odd[idx]   = m_lo1;
            end
            default: ;
        endcase
    endtask

    function automatic logic window_hit(input logic [31:0] w, input logic [31:0] va);
        logic plv_ok;
        plv_ok = ((m_crmd[1:0] == 2'd0) && w[0]) || ((m_crmd[1:0] == 2'd3) && w[3]);
        return plv_ok && (w[31:29] == va[31:29]);
    endfunction

    function automatic xlate_rsp_t model_xlate(input logic is_fetch, input logic [31:0] va);
        xlate_rsp_t  r;
        logic        found;
        logic [31:0] lo;
        r       = '0;
        r.valid = 1'b1;
        found   = 1'b0;
        lo      = '0;
        if (m_crmd[3]) begin
            r.paddr = va;
            r.mat   = is_fetch ? m_crmd[6:5] : m_crmd[8:7];
            r.src   = XLATE_DIRECT;
        end else if (window_hit(m_dmw0, va)) begin
            r.paddr = {m_dmw0[27:25], va[28:0]};
            r.mat   = m_dmw0[5:4];
            r.src   = XLATE_DMW;
        end else if (window_hit(m_dmw1, va)) begin
            r.paddr = {m_dmw1[27:25], va[28:0]};
            r.mat   = m_dmw1[5:4];
            r.src   = XLATE_DMW;
        end else begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                if (m_e[i] && (m_vppn[i] == va[31:13])
                        && (m_g[i] || (m_easid[i] == m_asid[9:0]))) begin
                    found = 1'b1;
                    lo    = va[12] ? m_odd[i] : m_even[i];
                end
            end
            if (found) begin
                r.paddr   = {lo[31:12], va[11:0]};
                r.mat     = lo[5:4];
                r.src     = XLATE_TLB;
                r.invalid = !lo[0];
            end else begin
                r.src = XLATE_MISS;
            end
        end
        return r;
    endfunction

    // Wishbone classic master that returns in the ack cycle
    task automatic bus_access(input logic we, input logic [13:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic reg_write(input logic [13:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        bus_access(1'b1, adr, dat, unused_rd);
        model_write(adr, dat);
    endtask

    task automatic reg_check(input logic [13:0] adr);
        logic [31:0] rd;
        logic [31:0] exp_rd;
        exp_rd = model_read(adr);
        bus_access(1'b0, adr, 32'h0, rd);
        assert (rd === exp_rd)
            else fail_value($sformatf("read of register %h", adr), 64'(exp_rd), 64'(rd));
    endtask

    task automatic send_req(input logic fv, input logic [31:0] fva,
                            input logic dv, input logic [31:0] dva);
        fetch_req.valid = fv;
        fetch_req.vaddr = fva;
        fetch_exp       = fv ? model_xlate(1'b1, fva) : '0;
        data_req.valid  = dv;
        data_req.vaddr  = dva;
        data_exp        = dv ? model_xlate(1'b0, dva) : '0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_ports();
        fetch_req.valid = 1'b0;
        data_req.valid  = 1'b0;
        fetch_exp       = '0;
        data_exp        = '0;
    endtask

    // Back to back on both ports for the first half and random gaps after
    task automatic direct_burst(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $urandom;
            send_req((i < n / 2) || r[0], $urandom, (i < n / 2) || r[1], $urandom);
        end
        idle_ports();
    endtask

    // Segments 4 to 6 cover both windows and a miss
    task automatic window_burst(input int n);
        logic [31:0] fva;
        logic [31:0] dva;
        for (int i = 0; i < n; i++) begin
            fva        = $urandom;
            dva        = $urandom;
            fva[31:29] = 3'(4 + $urandom % 3);
            dva[31:29] = 3'(4 + $urandom % 3);
            send_req(1'b1, fva, 1'b1, dva);
        end
        idle_ports();
    endtask

    function automatic logic [31:0] tlb_vaddr();
        logic [31:0] va;
        va = $urandom;
        case ($urandom % 5)
            0:       va[31:13] = 19'h12345;
            1:       va[31:13] = 19'h0ABCD;
            2:       va[31:13] = 19'h54321;
            3:       va[31:13] = 19'h12346;
            default: ;
        endcase
        return va;
    endfunction

    task automatic tlb_burst(input int n);
        for (int i = 0; i < n; i++) begin
            send_req(1'b1, tlb_vaddr(), 1'b1, tlb_vaddr());
        end
        idle_ports();
    endtask

    // New entry is visible one cycle after the command completes
    task automatic tlb_load(input logic [3:0] idx, input logic ne, input logic [18:0] vppn,
                            input logic [31:0] lo0, input logic [31:0] lo1);
        reg_write(`MMU_CSR_TLBIDX, {ne, 27'b0, idx});
        reg_write(`MMU_CSR_TLBEHI, {vppn, 13'b0});
        reg_write(`MMU_CSR_TLBELO0, lo0);
        reg_write(`MMU_CSR_TLBELO1, lo1);
        reg_write(`MMU_CSR_TLBCMD, $urandom);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            fetch_exp_q <= '0;
            data_exp_q  <= '0;
        end else begin
            fetch_exp_q <= fetch_exp;
            data_exp_q  <= data_exp;
        end
    end

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack
    ) else fail_plain("ack stayed high for more than one cycle");

    ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack
    ) else fail_plain("ack did not follow a bus request after one cycle");

    fetch_valid_chk: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_rsp.valid == fetch_exp_q.valid
    ) else fail_value("fetch valid", 64'($sampled(fetch_exp_q.valid)),
                      64'($sampled(fetch_rsp.valid)));

    fetch_rsp_chk: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_exp_q.valid |-> (fetch_rsp == fetch_exp_q)
    ) else fail_value("fetch response", 64'($sampled(fetch_exp_q)), 64'($sampled(fetch_rsp)));

    data_valid_chk: assert property (
        @(posedge clk) disable iff (!rst_n) data_rsp.valid == data_exp_q.valid
    ) else fail_value("data valid", 64'($sampled(data_exp_q.valid)),
                      64'($sampled(data_rsp.valid)));

    data_rsp_chk: assert property (
        @(posedge clk) disable iff (!rst_n) data_exp_q.valid |-> (data_rsp == data_exp_q)
    ) else fail_value("data response", 64'($sampled(data_exp_q)), 64'($sampled(data_rsp)));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        wb_req      = '0;
        fetch_req   = '0;
        data_req    = '0;
        fetch_exp   = '0;
        data_exp    = '0;
        test_name   = "reset";
        m_crmd      = 32'h8;
        m_asid      = '0;
        m_idx       = '0;
        m_ehi       = '0;
        m_lo0       = '0;
        m_lo1       = '0;
        m_dmw0      = '0;
        m_dmw1      = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            m_e[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int k = 0; k < 10; k++) begin
            reg_check(csr_addr(k));
        end

        test_name = "register access";
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 10; k++) begin
                if (k != 8) begin
                    reg_write(csr_addr(k), $urandom);
                end
            end
            for (int k = 0; k < 10; k++) begin
                reg_check(csr_addr(k));
            end
        end

        test_name = "direct";
        reg_write(`MMU_CSR_CRMD, 32'h0000_0128);
        direct_burst(32);
        reg_write(`MMU_CSR_CRMD, 32'h8 | ($urandom & 32'h1E0));
        direct_burst(32);

        // Both windows on segment 5 and later DMW1 on segment 4 for level 3 only
        test_name = "windows";
        reg_write(`MMU_CSR_DMW0, 32'hA200_0011);
        reg_write(`MMU_CSR_DMW1, 32'hA400_0029);
        reg_write(`MMU_CSR_CRMD, 32'h0000_0010);
        window_burst(12);
        reg_write(`MMU_CSR_CRMD, 32'h0000_0013);
        window_burst(12);
        reg_write(`MMU_CSR_DMW1, 32'h8E00_0038);
        window_burst(12);
        reg_write(`MMU_CSR_CRMD, 32'h0000_0010);
        window_burst(12);

        test_name = "tlb";
        reg_write(`MMU_CSR_DMW0, 32'h0);
        reg_write(`MMU_CSR_DMW1, 32'h0);
        reg_write(`MMU_CSR_ASID, 32'h21);
        tlb_load(4'd0, 1'b0, 19'h12345, ($urandom & 32'hFFFF_F000) | 32'h11,
                 ($urandom & 32'hFFFF_F000) | 32'h20);
        tlb_load(4'd5, 1'b0, 19'h0ABCD, ($urandom & 32'hFFFF_F000) | 32'h51,
                 ($urandom & 32'hFFFF_F000) | 32'h71);
        tlb_load(4'd9, 1'b1, 19'h54321, ($urandom & 32'hFFFF_F000) | 32'h11,
                 ($urandom & 32'hFFFF_F000) | 32'h11);
        reg_write(`MMU_CSR_ASID, 32'h22);
        tlb_load(4'd15, 1'b0, 19'h12346, ($urandom & 32'hFFFF_F000) | 32'h31,
                 ($urandom & 32'hFFFF_F000) | 32'h01);
        reg_write(`MMU_CSR_ASID, 32'h21);
        tlb_burst(20);
        reg_write(`MMU_CSR_ASID, 32'h22);
        tlb_burst(20);
        reg_write(`MMU_CSR_ASID, 32'h3FF);
        tlb_burst(20);

        repeat (3) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/tlb_pkg.sv
verilog/mmu_csr.sv
verilog/tlb_array.sv
verilog/addr_xlate.sv
verilog/mmu_top.sv
dv/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Build the MMU testbench with Verilator, run it and scan the log

verilator --binary --assert --top-module mmu_tb -f filelist.f -o mmu_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0
